/* Bender.yml */
package:
  name: vec_display

sources:
  - hdl/vec_pkg.sv
  - hdl/vec_rom.sv
  - hdl/vec_sequencer.sv
  - hdl/vec_axis_interp.sv
  - hdl/vec_beam_out.sv
  - hdl/vec_display_top.sv
  - target: test
    files:
      - test/tb_vec_display.sv

/* build.f */
hdl/vec_pkg.sv
hdl/vec_rom.sv
hdl/vec_sequencer.sv
hdl/vec_axis_interp.sv
hdl/vec_beam_out.sv
hdl/vec_display_top.sv
test/tb_vec_display.sv

/* hdl/vec_axis_interp.sv */
`timescale 1ns/1ps

module vec_axis_interp
    import vec_pkg::*;
(
    input  logic               clk,
    input  logic               arst_n,
    input  logic               seg_start,
    input  logic [COORD_W-1:0] seg_target,
    input  logic [COORD_W-1:0] seg_steps,
    input  logic               seg_jump,
    output logic [COORD_W-1:0] coord,
    output logic               coord_valid,
    output logic               seg_last
);

    logic [COORD_W-1:0] mag;
    logic               neg;
    logic [COORD_W-1:0] mag_q;
    logic [COORD_W-1:0] n_q;
    logic               neg_q;
    logic [COORD_W-1:0] cnt;
    logic [COORD_W:0]   err;
    logic [COORD_W:0]   acc;
    logic [COORD_W-1:0] acc_n;
    logic               acc_neg;
    logic               carry;
    logic [COORD_W:0]   acc_next;
    logic [COORD_W-1:0] coord_step;

    assign neg = (seg_target < coord);
    assign mag = neg ? (coord - seg_target) : (seg_target - coord);

    // Error accumulator; seeded with N/2 for half-up rounding.
    always_comb begin
        if (seg_start) begin
            acc     = {1'b0, seg_steps >> 1} + {1'b0, mag};
            acc_n   = seg_steps;
            acc_neg = neg;
        end else begin
            acc     = err + {1'b0, mag_q};
            acc_n   = n_q;
            acc_neg = neg_q;
        end
    end

    // Distance never exceeds N, so one carry per step at most.
    assign carry      = (acc >= {1'b0, acc_n});
    assign acc_next   = carry ? (acc - {1'b0, acc_n}) : acc;
    assign coord_step = !carry ? coord : (acc_neg ? coord - 1'b1 : coord + 1'b1);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            coord       <= '0;
            coord_valid <= 1'b0;
            seg_last    <= 1'b0;
            cnt         <= '0;
        end else if (seg_start) begin
            coord_valid <= 1'b1;
            if (seg_jump || seg_steps == '0) begin
                coord    <= seg_target;
                cnt      <= '0;
                seg_last <= 1'b1;
            end else begin
                coord    <= coord_step;
                cnt      <= seg_steps - 1'b1;
                seg_last <= (seg_steps == 8'd1);
            end
        end else if (cnt != '0) begin
            coord       <= coord_step;
            cnt         <= cnt - 1'b1;
            coord_valid <= 1'b1;
            seg_last    <= (cnt == 8'd1);
        end else begin
            coord_valid <= 1'b0;
            seg_last    <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (seg_start) begin
            n_q   <= seg_steps;
            mag_q <= mag;
            neg_q <= neg;
            err   <= acc_next;
        end else if (cnt != '0) begin
            err <= acc_next;
        end
    end

endmodule

/* hdl/vec_beam_out.sv */
`timescale 1ns/1ps

module vec_beam_out
    import vec_pkg::*;
(
    input  logic                             clk,
    input  logic                             arst_n,
    input  logic [NUM_AXES-1:0][COORD_W-1:0] coord,
    input  logic                             coord_valid,
    input  logic                             beam_en,
    input  logic                             pic_end,
    output logic                             point_valid,
    output logic [COORD_W-1:0]               point_x,
    output logic [COORD_W-1:0]               point_y,
    output logic                             beam_on,
    output logic                             frame_done
);

    // Point strobe and end strobe.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            point_valid <= 1'b0;
            frame_done  <= 1'b0;
        end else begin
            point_valid <= coord_valid;
            frame_done  <= pic_end;
        end
    end

    // Beam holds its last point between strobes.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            point_x <= '0;
            point_y <= '0;
            beam_on <= 1'b0;
        end else if (coord_valid) begin
            point_x <= coord[0];
            point_y <= coord[1];
            beam_on <= beam_en;
        end
    end

endmodule

/* hdl/vec_display_top.sv */
`timescale 1ns/1ps

module vec_display_top
    import vec_pkg::*;
(
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 start,
    input  logic [PIC_SEL_W-1:0] pic_sel,
    output logic                 point_valid,
    output logic [COORD_W-1:0]   point_x,
    output logic [COORD_W-1:0]   point_y,
    output logic                 beam_on,
    output logic                 frame_done,
    output logic                 busy
);

    logic [ADDR_W-1:0]                rom_addr;
    logic [ENTRY_W-1:0]               rom_entry;
    logic                             seg_start;
    logic [NUM_AXES-1:0][COORD_W-1:0] seg_target;
    logic [COORD_W-1:0]               seg_steps;
    logic                             seg_jump;
    logic                             beam_en;
    logic                             pic_end;
    logic [NUM_AXES-1:0][COORD_W-1:0] coord;
    logic [NUM_AXES-1:0]              coord_valid;
    logic [NUM_AXES-1:0]              seg_last;

    vec_sequencer u_seq (
        .clk        (clk),
        .arst_n     (arst_n),
        .start      (start),
        .pic_sel    (pic_sel),
        .rom_entry  (rom_entry),
        .seg_last   (seg_last[0]),
        .rom_addr   (rom_addr),
        .seg_start  (seg_start),
        .seg_target (seg_target),
        .seg_steps  (seg_steps),
        .seg_jump   (seg_jump),
        .beam_en    (beam_en),
        .pic_end    (pic_end),
        .busy       (busy)
    );

    vec_rom u_rom (
        .rom_addr  (rom_addr),
        .rom_entry (rom_entry)
    );

    // Axes share the step count and run in lockstep.
    for (genvar i = 0; i < NUM_AXES; i++) begin : g_axis
        vec_axis_interp u_axis (
            .clk         (clk),
            .arst_n      (arst_n),
            .seg_start   (seg_start),
            .seg_target  (seg_target[i]),
            .seg_steps   (seg_steps),
            .seg_jump    (seg_jump),
            .coord       (coord[i]),
            .coord_valid (coord_valid[i]),
            .seg_last    (seg_last[i])
        );
    end

    vec_beam_out u_out (
        .clk         (clk),
        .arst_n      (arst_n),
        .coord       (coord),
        .coord_valid (coord_valid[0]),
        .beam_en     (beam_en),
        .pic_end     (pic_end),
        .point_valid (point_valid),
        .point_x     (point_x),
        .point_y     (point_y),
        .beam_on     (beam_on),
        .frame_done  (frame_done)
    );

endmodule

/* hdl/vec_pkg.sv */
package vec_pkg;

    // Beam coordinate width, one per axis.
    localparam int COORD_W = 8;

    // Axis 0 is x, axis 1 is y.
    localparam int NUM_AXES = 2;

    // Picture ROM depth is 2**ADDR_W entries.
    localparam int ADDR_W = 6;

    // Entry layout from the top bit down: x, y, line flag, position flag.
    localparam int ENTRY_W        = 2 * COORD_W + 2;
    localparam int ENTRY_X_LSB    = ENTRY_W - COORD_W;
    localparam int ENTRY_Y_LSB    = 2;
    localparam int ENTRY_LINE_BIT = 1;
    localparam int ENTRY_POS_BIT  = 0;

    // Picture start addresses.
    localparam logic [ADDR_W-1:0] PIC_MAP_BASE   = 6'd0;
    localparam logic [ADDR_W-1:0] PIC_FRAME_BASE = 6'd42;

    localparam int NUM_PICS  = 2;
    localparam int PIC_SEL_W = $clog2(NUM_PICS);

endpackage

/* hdl/vec_rom.sv */
`timescale 1ns/1ps

module vec_rom
    import vec_pkg::*;
(
    input  logic [ADDR_W-1:0]  rom_addr,
    output logic [ENTRY_W-1:0] rom_entry
);

    // Each row is {x, y, line, pos}.
    always_comb begin
        unique case (rom_addr)
            // Map picture.
            6'd0:  rom_entry = {8'd150, 8'd255, 1'b0, 1'b1};
            6'd1:  rom_entry = {8'd142, 8'd227, 1'b1, 1'b0};
            6'd2:  rom_entry = {8'd131, 8'd225, 1'b1, 1'b0};
            6'd3:  rom_entry = {8'd132, 8'd245, 1'b1, 1'b0};
            6'd4:  rom_entry = {8'd111, 8'd209, 1'b1, 1'b0};
            6'd5:  rom_entry = {8'd120, 8'd197, 1'b1, 1'b0};
            6'd6:  rom_entry = {8'd101, 8'd187, 1'b1, 1'b0};
            6'd7:  rom_entry = {8'd104, 8'd175, 1'b1, 1'b0};
            6'd8:  rom_entry = {8'd108, 8'd132, 1'b1, 1'b0};
            6'd9:  rom_entry = {8'd82,  8'd87,  1'b1, 1'b0};
            6'd10: rom_entry = {8'd100, 8'd60,  1'b1, 1'b0};
            6'd11: rom_entry = {8'd97,  8'd39,  1'b1, 1'b0};
            6'd12: rom_entry = {8'd75,  8'd68,  1'b1, 1'b0};
            6'd13: rom_entry = {8'd43,  8'd71,  1'b1, 1'b0};
            6'd14: rom_entry = {8'd0,   8'd55,  1'b1, 1'b0};
            6'd15: rom_entry = {8'd0,   8'd218, 1'b0, 1'b1};
            6'd16: rom_entry = {8'd15,  8'd223, 1'b1, 1'b0};
            6'd17: rom_entry = {8'd59,  8'd204, 1'b1, 1'b0};
            6'd18: rom_entry = {8'd56,  8'd190, 1'b1, 1'b0};
            6'd19: rom_entry = {8'd85,  8'd205, 1'b1, 1'b0};
            6'd20: rom_entry = {8'd60,  8'd205, 1'b1, 1'b0};
            6'd21: rom_entry = {8'd44,  8'd169, 1'b1, 1'b0};
            6'd22: rom_entry = {8'd46,  8'd183, 1'b1, 1'b0};
            6'd23: rom_entry = {8'd31,  8'd195, 1'b1, 1'b0};
            6'd24: rom_entry = {8'd30,  8'd165, 1'b1, 1'b0};
            6'd25: rom_entry = {8'd20,  8'd159, 1'b1, 1'b0};
            6'd26: rom_entry = {8'd12,  8'd197, 1'b1, 1'b0};
            6'd27: rom_entry = {8'd21,  8'd206, 1'b1, 1'b0};
            6'd28: rom_entry = {8'd0,   8'd203, 1'b1, 1'b0};
            6'd29: rom_entry = {8'd78,  8'd13,  1'b0, 1'b1};
            6'd30: rom_entry = {8'd110, 8'd28,  1'b1, 1'b0};
            6'd31: rom_entry = {8'd152, 8'd23,  1'b1, 1'b0};
            6'd32: rom_entry = {8'd130, 8'd11,  1'b1, 1'b0};
            6'd33: rom_entry = {8'd107, 8'd16,  1'b1, 1'b0};
            6'd34: rom_entry = {8'd77,  8'd12,  1'b1, 1'b0};
            6'd35: rom_entry = {8'd158, 8'd10,  1'b0, 1'b1};
            6'd36: rom_entry = {8'd162, 8'd25,  1'b1, 1'b0};
            6'd37: rom_entry = {8'd183, 8'd32,  1'b1, 1'b0};
            6'd38: rom_entry = {8'd198, 8'd30,  1'b1, 1'b0};
            6'd39: rom_entry = {8'd177, 8'd9,   1'b1, 1'b0};
            6'd40: rom_entry = {8'd156, 8'd8,   1'b1, 1'b0};
            // Address 41 falls to the default and ends the map.

            // Frame picture, a full-screen rectangle.
            6'd42: rom_entry = {8'd0,   8'd255, 1'b0, 1'b1};
            6'd43: rom_entry = {8'd0,   8'd0,   1'b1, 1'b0};
            6'd44: rom_entry = {8'd255, 8'd0,   1'b1, 1'b0};
            6'd45: rom_entry = {8'd255, 8'd255, 1'b1, 1'b0};
            6'd46: rom_entry = {8'd0,   8'd255, 1'b1, 1'b0};
            6'd47: rom_entry = {8'd0,   8'd255, 1'b1, 1'b1};

            default: rom_entry = '0;
        endcase
    end

endmodule

/* hdl/vec_sequencer.sv */
`timescale 1ns/1ps

module vec_sequencer
    import vec_pkg::*;
(
    input  logic                               clk,
    input  logic                               arst_n,
    input  logic                               start,
    input  logic [PIC_SEL_W-1:0]               pic_sel,
    input  logic [ENTRY_W-1:0]                 rom_entry,
    input  logic                               seg_last,
    output logic [ADDR_W-1:0]                  rom_addr,
    output logic                               seg_start,
    output logic [NUM_AXES-1:0][COORD_W-1:0]   seg_target,
    output logic [COORD_W-1:0]                 seg_steps,
    output logic                               seg_jump,
    output logic                               beam_en,
    output logic                               pic_end,
    output logic                               busy
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_FETCH,
        S_RUN,
        S_END
    } state_t;

    state_t                             state;
    logic [ADDR_W-1:0]                  addr;
    logic [NUM_AXES-1:0][COORD_W-1:0]   cur_pt;
    logic [NUM_AXES-1:0][COORD_W-1:0]   ent_pt;
    logic [NUM_AXES-1:0][COORD_W-1:0]   delta;
    logic [COORD_W-1:0]                 steps;
    logic                               ent_line;
    logic                               ent_pos;
    logic                               is_move;
    logic                               is_end;
    logic                               line_q;

    // Entry fields.
    assign ent_pt[0] = rom_entry[ENTRY_X_LSB +: COORD_W];
    assign ent_pt[1] = rom_entry[ENTRY_Y_LSB +: COORD_W];
    assign ent_line  = rom_entry[ENTRY_LINE_BIT];
    assign ent_pos   = rom_entry[ENTRY_POS_BIT];

    // Equal flags, including the all-zero entry, end the picture.
    assign is_move = ent_pos & ~ent_line;
    assign is_end  = ~(ent_pos ^ ent_line);

    // Segment length is the largest axis distance.
    always_comb begin
        steps = '0;
        for (int a = 0; a < NUM_AXES; a++) begin
            if (ent_pt[a] >= cur_pt[a]) begin
                delta[a] = ent_pt[a] - cur_pt[a];
            end else begin
                delta[a] = cur_pt[a] - ent_pt[a];
            end
            if (delta[a] > steps) begin
                steps = delta[a];
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state  <= S_IDLE;
            addr   <= '0;
            cur_pt <= '0;
            line_q <= 1'b0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (start) begin
                        addr  <= (pic_sel != '0) ? PIC_FRAME_BASE : PIC_MAP_BASE;
                        state <= S_FETCH;
                    end
                end
                S_FETCH: begin
                    if (is_end) begin
                        state <= S_END;
                    end else begin
                        // Beam ends the segment on the entry point.
                        cur_pt <= ent_pt;
                        line_q <= ent_line;
                        state  <= S_RUN;
                    end
                end
                S_RUN: begin
                    if (seg_last) begin
                        addr  <= addr + 1'b1;
                        state <= S_FETCH;
                    end
                end
                default: begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

    assign rom_addr   = addr;
    assign seg_start  = (state == S_FETCH) && !is_end;
    assign pic_end    = (state == S_FETCH) && is_end;
    assign seg_target = ent_pt;
    assign seg_steps  = steps;
    assign seg_jump   = is_move;
    assign beam_en    = line_q;
    assign busy       = (state != S_IDLE);

endmodule

/* test/tb_vec_display.sv */
`timescale 1ns/1ps

module tb_vec_display
    import vec_pkg::*;
();

    localparam int NUM_FRAMES = 5;

    logic               clk;
    logic               arst_n;
    logic               start;
    logic [PIC_SEL_W-1:0] pic_sel;
    logic               point_valid;
    logic [COORD_W-1:0] point_x;
    logic [COORD_W-1:0] point_y;
    logic               beam_on;
    logic               frame_done;
    logic               busy;

    // Picture copy by address. Flags: 1 position, 2 line, 0 or 3 end.
    int pic_x [0:47] = '{150, 142, 131, 132, 111, 120, 101, 104, 108, 82, 100, 97, 75, 43, 0, 0,
                         15, 59, 56, 85, 60, 44, 46, 31, 30, 20, 12, 21, 0, 78, 110, 152,
                         130, 107, 77, 158, 162, 183, 198, 177, 156, 0, 0, 0, 255, 255, 0, 0};
    int pic_y [0:47] = '{255, 227, 225, 245, 209, 197, 187, 175, 132, 87, 60, 39, 68, 71, 55, 218,
                         223, 204, 190, 205, 205, 169, 183, 195, 165, 159, 197, 206, 203, 13, 28, 23,
                         11, 16, 12, 10, 25, 32, 30, 9, 8, 0, 255, 0, 0, 255, 255, 255};
    int pic_f [0:47] = '{1, 2, 2, 2, 2, 2, 2, 2, 2, 2, 2, 2, 2, 2, 2, 1,
                         2, 2, 2, 2, 2, 2, 2, 2, 2, 2, 2, 2, 2, 1, 2, 2,
                         2, 2, 2, 1, 2, 2, 2, 2, 2, 0, 1, 2, 2, 2, 2, 3};

    logic [COORD_W-1:0] exp_x [$];
    logic [COORD_W-1:0] exp_y [$];
    logic               exp_b [$];
    int                 exp_count [$];

    int          ref_x = 0;
    int          ref_y = 0;
    int          ref_entries = 0;
    logic [15:0] lfsr = 16'd32;
    int          point_errors = 0;
    int          count_errors = 0;
    int          flag_errors = 0;
    int          frame_points = 0;
    int          frames_seen = 0;
    int          point_index = 0;
    int          cycle_count = 0;
    int          cycle_limit = 0;

    vec_display_top u_dut (
        .clk         (clk),
        .arst_n      (arst_n),
        .start       (start),
        .pic_sel     (pic_sel),
        .point_valid (point_valid),
        .point_x     (point_x),
        .point_y     (point_y),
        .beam_on     (beam_on),
        .frame_done  (frame_done),
        .busy        (busy)
    );

    always #50 clk = ~clk;

    // Galois LFSR, x^16 + x^14 + x^13 + x^11 + 1.
    function automatic int take_bits(input int n);
        int val;
        val = 0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
            val  = (val << 1) | lfsr[0];
        end
        return val;
    endfunction

    // Signed distance after step k of n, rounded half up.
    function automatic int axis_offset(input int d, input int k, input int n);
        int mag;
        mag = (d < 0) ? -d : d;
        mag = (2 * mag * k + n) / (2 * n);
        return (d < 0) ? -mag : mag;
    endfunction

    // Appends the expected points of one picture, returns their number.
    function automatic int expand_picture(input int sel);
        int a;
        int n;
        int dx;
        int dy;
        int pts;
        bit done;
        a = (sel != 0) ? 42 : 0;
        pts = 0;
        done = 0;
        ref_entries = 0;
        while (!done) begin
            ref_entries++;
            if (pic_f[a] == 0 || pic_f[a] == 3) begin
                done = 1;
            end else begin
                dx = pic_x[a] - ref_x;
                dy = pic_y[a] - ref_y;
                n  = ((dx < 0) ? -dx : dx) > ((dy < 0) ? -dy : dy) ?
                     ((dx < 0) ? -dx : dx) : ((dy < 0) ? -dy : dy);
                if (pic_f[a] == 1 || n == 0) begin
                    exp_x.push_back(pic_x[a]);
                    exp_y.push_back(pic_y[a]);
                    exp_b.push_back(pic_f[a] == 2);
                    pts++;
                end else begin
                    for (int k = 1; k <= n; k++) begin
                        exp_x.push_back(ref_x + axis_offset(dx, k, n));
                        exp_y.push_back(ref_y + axis_offset(dy, k, n));
                        exp_b.push_back(1'b1);
                        pts++;
                    end
                end
                ref_x = pic_x[a];
                ref_y = pic_y[a];
                a++;
            end
        end
        return pts;
    endfunction

    task automatic check_point(
        input logic [COORD_W-1:0] got_x,
        input logic [COORD_W-1:0] got_y,
        input logic               got_b,
        input logic [COORD_W-1:0] want_x,
        input logic [COORD_W-1:0] want_y,
        input logic               want_b
    );
        if (got_x !== want_x || got_y !== want_y || got_b !== want_b) begin
            point_errors++;
            $display("FAIL %0t: point %0d is (%0d, %0d) beam %0b, expected (%0d, %0d) beam %0b",
                     $time, point_index, got_x, got_y, got_b, want_x, want_y, want_b);
        end
    endtask

    task automatic check_count(input int got, input int want, input string what);
        if (got != want) begin
            count_errors++;
            $display("FAIL %0t: %s is %0d, expected %0d", $time, what, got, want);
        end
    endtask

    task automatic check_flag(input logic got, input logic want, input string what);
        if (got !== want) begin
            flag_errors++;
            $display("FAIL %0t: %s is %b, expected %b", $time, what, got, want);
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #10;
    endtask

    // Point and frame checker, sampled mid-cycle.
    always @(negedge clk) begin : compare
        if (arst_n && point_valid) begin
            if (exp_x.size() == 0) begin
                flag_errors++;
                $display("Point at %0t arrived with no point expected", $time);
            end else begin
                check_point(point_x, point_y, beam_on,
                            exp_x.pop_front(), exp_y.pop_front(), exp_b.pop_front());
            end
            point_index++;
            frame_points++;
        end
        if (arst_n && frame_done) begin
            if (exp_count.size() == 0) begin
                flag_errors++;
                $display("Frame end at %0t arrived with no frame running", $time);
            end else begin
                check_count(frame_points, exp_count.pop_front(), "points in frame");
            end
            frame_points = 0;
            frames_seen++;
        end
    end

    initial begin
        wait (cycle_limit > 0);
        while (cycle_count < cycle_limit) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Run stopped by timeout after %0d cycles", cycle_count);
        $display("Test failed");
        $finish;
    end

    initial begin
        int sel;
        int gap;
        int lat;
        int target;
        int size_map;
        int size_frame;
        clk     = 1'b0;
        arst_n  = 1'b0;
        start   = 1'b0;
        pic_sel = '0;

        // Run length from the reference lists.
        size_frame = expand_picture(1);
        size_frame += ref_entries;
        size_map = expand_picture(0);
        size_map += ref_entries;
        exp_x.delete();
        exp_y.delete();
        exp_b.delete();
        ref_x = 0;
        ref_y = 0;
        cycle_limit = 6 * (((size_map > size_frame) ? size_map : size_frame) + 10);

        repeat (4) @(posedge clk);
        #10;
        arst_n = 1'b1;

        // Idle after reset.
        repeat (5) begin
            next_cycle();
            check_flag(point_valid, 1'b0, "point_valid while idle");
            check_flag(frame_done, 1'b0, "frame_done while idle");
            check_flag(busy, 1'b0, "busy while idle");
        end

        for (int f = 0; f < NUM_FRAMES; f++) begin
            gap = take_bits(3);
            sel = (f < 2) ? 1 - f : take_bits(1);
            repeat (gap) next_cycle();
            exp_count.push_back(expand_picture(sel));
            start   = 1'b1;
            pic_sel = sel[PIC_SEL_W-1:0];
            next_cycle();
            start = 1'b0;
            lat = 1;
            while (!point_valid && lat < 8) begin
                next_cycle();
                lat++;
            end
            check_count(lat, 3, "cycles from start to first point");

            // A start while busy must be ignored.
            if (f >= 2) begin
                repeat (5) next_cycle();
                check_flag(busy, 1'b1, "busy during picture");
                start   = 1'b1;
                pic_sel = ~pic_sel;
                next_cycle();
                start = 1'b0;
            end

            target = f + 1;
            while (frames_seen < target) begin
                next_cycle();
            end
            while (busy) begin
                next_cycle();
            end
        end

        repeat (3) next_cycle();
        $display("Errors: point %0d, count %0d, other %0d",
                 point_errors, count_errors, flag_errors);
        if (point_errors + count_errors + flag_errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule
